// File: common/div_types_pkg.sv
`default_nettype none

package div_types_pkg;

  // Operand widths.
  localparam int DIVIDEND_W = 16;
  localparam int DIVISOR_W  = 8;

  // One divide request as presented at the top level.
  typedef struct packed {
    logic [DIVIDEND_W-1:0] dividend;
    logic [DIVISOR_W-1:0]  divisor;
  } div_req_t;

  // Result word; err marks divide by zero or quotient overflow.
  typedef struct packed {
    logic [DIVISOR_W-1:0] quotient;
    logic [DIVISOR_W-1:0] remainder;
    logic                 err;
  } div_resp_t;

endpackage

`default_nettype wire

// File: common/div_cell_pkg.sv
`default_nettype none

package div_cell_pkg;

  // Truth table of one cell output, bit n is the output for input index n.
  // The index is {x, y, borrow_in}, so x is the most significant bit.
  typedef logic [7:0] cell_tt_t;

  // Exact full subtractor, difference is x ^ y ^ bin.
  localparam cell_tt_t EXACT_DIFF_TT = 8'h96;

  // Exact borrow, set for ~x & y or for x == y with a borrow in.
  localparam cell_tt_t EXACT_BORROW_TT = 8'h8E;

  // Approximate difference.
  // High for every input except all zeros.
  localparam cell_tt_t APPROX_DIFF_TT = 8'hFE;

  // Approximate borrow.
  // High for indices 0, 1, 3, 4, 5 and 7.
  localparam cell_tt_t APPROX_BORROW_TT = 8'hBB;

endpackage

`default_nettype wire

// File: divider/div_cell.sv
`default_nettype none

module div_cell #(
  parameter int APPROX = 0
) (
  input  logic x,
  input  logic y,
  input  logic borrow_in,
  input  logic restore_n,
  output logic rem_out,
  output logic borrow_out
);

  localparam div_cell_pkg::cell_tt_t DIFF_TT =
    (APPROX != 0) ? div_cell_pkg::APPROX_DIFF_TT : div_cell_pkg::EXACT_DIFF_TT;
  localparam div_cell_pkg::cell_tt_t BORROW_TT =
    (APPROX != 0) ? div_cell_pkg::APPROX_BORROW_TT : div_cell_pkg::EXACT_BORROW_TT;

  logic [2:0] idx;
  logic       diff;

  assign idx        = {x, y, borrow_in};
  assign diff       = DIFF_TT[idx];
  assign borrow_out = BORROW_TT[idx];

  // Restore the partial remainder when the row does not subtract.
  assign rem_out = restore_n ? diff : x;

endmodule

`default_nettype wire

// File: divider/div_array.sv
`default_nettype none

module div_array #(
  parameter int APPROX_ROWS = 4
) (
  input  div_types_pkg::div_req_t req,
  output logic [7:0]              quotient,
  output logic [7:0]              remainder
);

  localparam int W   = div_types_pkg::DIVISOR_W;
  localparam int TOP = div_types_pkg::DIVIDEND_W - 1;

  // Row i resolves quotient bit i; row W-1 works first on the dividend.
  // Each cell keeps its own nets so the borrow chain stays bit-level.
  for (genvar i = 0; i < W; i++) begin : g_row
    logic q_bit;

    for (genvar j = 0; j < W; j++) begin : g_col
      logic x_in;
      logic b_in;
      logic rem;
      logic b_out;

      if (j == 0) begin : g_lsb
        // Column 0 brings in the next dividend bit.
        assign x_in = req.dividend[i];
        assign b_in = 1'b0;
      end else begin : g_chain
        assign b_in = g_col[j-1].b_out;
        if (i == W - 1) begin : g_first_row
          assign x_in = req.dividend[W-1+j];
        end else begin : g_inner_row
          // Shifted partial remainder from the row above.
          assign x_in = g_row[i+1].g_col[j-1].rem;
        end
      end

      div_cell #(
        .APPROX (i < APPROX_ROWS ? 1 : 0)
      ) u_cell (
        .x          (x_in),
        .y          (req.divisor[j]),
        .borrow_in  (b_in),
        .restore_n  (q_bit),
        .rem_out    (rem),
        .borrow_out (b_out)
      );
    end

    // Subtract if the bit shifted out is set or the row did not borrow.
    if (i == W - 1) begin : g_q_first
      assign q_bit = req.dividend[TOP] | ~g_col[W-1].b_out;
    end else begin : g_q_inner
      assign q_bit = g_row[i+1].g_col[W-1].rem | ~g_col[W-1].b_out;
    end

    assign quotient[i] = q_bit;
  end

  // Final remainder is the output of the last row.
  for (genvar j = 0; j < W; j++) begin : g_rem
    assign remainder[j] = g_row[0].g_col[j].rem;
  end

endmodule

`default_nettype wire

// File: source/div_operand_stage.sv
`default_nettype none

module div_operand_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  div_types_pkg::div_req_t in_req,
  output logic                    stage_valid,
  output div_types_pkg::div_req_t stage_req,
  output logic                    stage_err
);

  localparam int W   = div_types_pkg::DIVISOR_W;
  localparam int TOP = div_types_pkg::DIVIDEND_W - 1;

  logic div_zero;
  logic overflow;

  assign div_zero = (in_req.divisor == '0);

  // Quotient would not fit in W bits.
  assign overflow = (in_req.dividend[TOP -: W] >= in_req.divisor);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_valid <= 1'b0;
      stage_req   <= '0;
      stage_err   <= 1'b0;
    end else begin
      stage_valid <= in_valid;
      if (in_valid) begin
        stage_req <= in_req;
        stage_err <= div_zero | overflow;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/div_result_stage.sv
`default_nettype none

module div_result_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     stage_valid,
  input  logic                     stage_err,
  input  logic [7:0]               quotient,
  input  logic [7:0]               remainder,
  output logic                     out_valid,
  output div_types_pkg::div_resp_t out_resp
);

  div_types_pkg::div_resp_t resp_next;

  // Error response is all ones quotient and zero remainder.
  always_comb begin
    if (stage_err) begin
      resp_next.quotient  = 8'hFF;
      resp_next.remainder = 8'h00;
      resp_next.err       = 1'b1;
    end else begin
      resp_next.quotient  = quotient;
      resp_next.remainder = remainder;
      resp_next.err       = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_resp  <= '0;
    end else begin
      out_valid <= stage_valid;
      if (stage_valid) begin
        out_resp <= resp_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/approx_divider_top.sv
`default_nettype none

module approx_divider_top #(
  parameter int APPROX_ROWS = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  input  div_types_pkg::div_req_t  in_req,
  output logic                     out_valid,
  output div_types_pkg::div_resp_t out_resp
);

  logic                    stage_valid;
  logic                    stage_err;
  div_types_pkg::div_req_t stage_req;
  logic [7:0]              arr_quotient;
  logic [7:0]              arr_remainder;

  div_operand_stage u_operand (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_req      (in_req),
    .stage_valid (stage_valid),
    .stage_req   (stage_req),
    .stage_err   (stage_err)
  );

  // Array settles between the two register stages.
  div_array #(
    .APPROX_ROWS (APPROX_ROWS)
  ) u_array (
    .req       (stage_req),
    .quotient  (arr_quotient),
    .remainder (arr_remainder)
  );

  div_result_stage u_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .stage_valid (stage_valid),
    .stage_err   (stage_err),
    .quotient    (arr_quotient),
    .remainder   (arr_remainder),
    .out_valid   (out_valid),
    .out_resp    (out_resp)
  );

endmodule

`default_nettype wire

// File: bench/div_checker.sv
`default_nettype none

module div_checker #(
  parameter int APPROX_ROWS = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  input  div_types_pkg::div_req_t  in_req,
  input  logic                     out_valid,
  input  div_types_pkg::div_resp_t out_resp,
  output int                       error_count,
  output int                       result_count,
  output int                       pending
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LATENCY = 2;

  div_types_pkg::div_resp_t exp_q[$];
  int                       cycle_q[$];
  div_types_pkg::div_resp_t exp_resp;
  int                       entry_cycle;
  int                       cycle_now = 0;
  int                       err_cnt = 0;
  int                       res_cnt = 0;
  int                       pend_cnt = 0;

  assign error_count  = err_cnt;
  assign result_count = res_cnt;
  assign pending      = pend_cnt;

  // Bit-level restoring division, one borrow-ripple row per quotient bit.
  function automatic div_types_pkg::div_resp_t expected_resp(
    input div_types_pkg::div_req_t req
  );
    div_types_pkg::div_resp_t resp;
    div_cell_pkg::cell_tt_t   diff_tt;
    div_cell_pkg::cell_tt_t   borrow_tt;
    logic [7:0]               part;
    logic [7:0]               x;
    logic [7:0]               diff;
    logic [2:0]               idx;
    logic                     top;
    logic                     borrow;
    logic                     q;
    resp = '0;
    if (req.divisor == 8'd0 || req.dividend[15:8] >= req.divisor) begin
      resp.quotient  = 8'hFF;
      resp.remainder = 8'h00;
      resp.err       = 1'b1;
      return resp;
    end
    part = req.dividend[15:8];
    for (int i = 7; i >= 0; i--) begin
      // Shift the next dividend bit into the partial remainder.
      top = part[7];
      x   = {part[6:0], req.dividend[i]};
      if (i < APPROX_ROWS) begin
        diff_tt   = div_cell_pkg::APPROX_DIFF_TT;
        borrow_tt = div_cell_pkg::APPROX_BORROW_TT;
      end else begin
        diff_tt   = div_cell_pkg::EXACT_DIFF_TT;
        borrow_tt = div_cell_pkg::EXACT_BORROW_TT;
      end
      borrow = 1'b0;
      for (int j = 0; j < 8; j++) begin
        idx     = {x[j], req.divisor[j], borrow};
        diff[j] = diff_tt[idx];
        borrow  = borrow_tt[idx];
      end
      q = top | ~borrow;
      resp.quotient[i] = q;
      part = q ? diff : x;
    end
    resp.remainder = part;
    return resp;
  endfunction

  task automatic report_mismatch(input string name, input logic [7:0] exp, input logic [7:0] got);
    $display("Fail %0t %s expected %02h got %02h", $time, name, exp, got);
    err_cnt++;
  endtask

  // Sampled on the falling edge, away from input and register updates.
  always @(negedge clk) begin
    cycle_now++;
    if (out_valid) begin
      if (exp_q.size() == 0) begin
        $display("Result at %0t arrived with no operation pending", $time);
        err_cnt++;
      end else begin
        exp_resp    = exp_q.pop_front();
        entry_cycle = cycle_q.pop_front();
        res_cnt++;
        if (cycle_now - entry_cycle != LATENCY) begin
          $display("Result at %0t came %0d cycles after its input instead of %0d",
                   $time, cycle_now - entry_cycle, LATENCY);
          err_cnt++;
        end
        if (out_resp.err !== exp_resp.err) begin
          report_mismatch("out_resp.err", 8'(exp_resp.err), 8'(out_resp.err));
        end
        if (out_resp.quotient !== exp_resp.quotient) begin
          report_mismatch("out_resp.quotient", exp_resp.quotient, out_resp.quotient);
        end
        if (out_resp.remainder !== exp_resp.remainder) begin
          report_mismatch("out_resp.remainder", exp_resp.remainder, out_resp.remainder);
        end
      end
    end else if (cycle_q.size() != 0 && cycle_now - cycle_q[0] >= LATENCY) begin
      $display("Result missing at %0t for an operation accepted %0d cycles earlier",
               $time, cycle_now - cycle_q[0]);
      err_cnt++;
      void'(exp_q.pop_front());
      void'(cycle_q.pop_front());
    end
    if (rst_n && in_valid) begin
      exp_q.push_back(expected_resp(in_req));
      cycle_q.push_back(cycle_now);
    end
    pend_cnt = cycle_q.size();
  end

endmodule

`default_nettype wire

// File: bench/tb_top.sv
`default_nettype none

module tb_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int APPROX_ROWS = 4;

  // About 3100 operations, gaps in the mixed test and drains, with margin.
  localparam int MAX_CYCLES = 4000;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     in_valid;
  div_types_pkg::div_req_t  in_req;
  logic                     out_valid;
  div_types_pkg::div_resp_t out_resp;
  int                       error_count;
  int                       result_count;
  int                       pending;
  int                       ops_sent = 0;
  int                       cycles = 0;

  always #4 clk = ~clk;

  approx_divider_top #(
    .APPROX_ROWS (APPROX_ROWS)
  ) u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_resp  (out_resp)
  );

  div_checker #(
    .APPROX_ROWS (APPROX_ROWS)
  ) u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_req       (in_req),
    .out_valid    (out_valid),
    .out_resp     (out_resp),
    .error_count  (error_count),
    .result_count (result_count),
    .pending      (pending)
  );

  // High byte below the divisor, so the quotient fits.
  function automatic div_types_pkg::div_req_t valid_req();
    div_types_pkg::div_req_t req;
    req.divisor         = 8'($urandom_range(255, 1));
    req.dividend[15:8]  = 8'($urandom_range(32'(req.divisor) - 1, 0));
    req.dividend[7:0]   = 8'($urandom);
    return req;
  endfunction

  function automatic div_types_pkg::div_req_t zero_req();
    div_types_pkg::div_req_t req;
    req.divisor  = 8'd0;
    req.dividend = 16'($urandom);
    return req;
  endfunction

  function automatic div_types_pkg::div_req_t overflow_req();
    div_types_pkg::div_req_t req;
    req.divisor        = 8'($urandom_range(255, 1));
    req.dividend[15:8] = 8'($urandom_range(255, 32'(req.divisor)));
    req.dividend[7:0]  = 8'($urandom);
    return req;
  endfunction

  // Called 1 ns after a rising edge; returns 1 ns after the next one.
  task automatic issue(input div_types_pkg::div_req_t req);
    in_valid = 1'b1;
    in_req   = req;
    ops_sent++;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    in_valid = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic finish_test(input int num, input string name, input int ops, input int err_before);
    while (pending != 0) begin
      idle(1);
    end
    idle(3);
    $display("Test %0d %s: %0d operations, %0d errors", num, name, ops, error_count - err_before);
  endtask

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the tests did not complete", cycles);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    int err_before;
    int kind;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_req   = '0;
    void'($urandom(32'hc03f48d2));
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // No result may appear without an input.
    err_before = error_count;
    idle(10);
    finish_test(1, "idle after reset", 0, err_before);

    err_before = error_count;
    for (int n = 0; n < 1000; n++) begin
      issue(valid_req());
    end
    finish_test(2, "random valid divides", 1000, err_before);

    err_before = error_count;
    for (int n = 0; n < 500; n++) begin
      issue(zero_req());
    end
    finish_test(3, "divide by zero", 500, err_before);

    err_before = error_count;
    for (int n = 0; n < 500; n++) begin
      issue(overflow_req());
    end
    finish_test(4, "quotient overflow", 500, err_before);

    err_before = error_count;
    for (int n = 0; n < 1100; n++) begin
      kind = $urandom_range(3, 0);
      if (kind < 2) begin
        issue(valid_req());
      end else if (kind == 2) begin
        issue(zero_req());
      end else begin
        issue(overflow_req());
      end
      if ($urandom_range(3, 0) == 0) begin
        idle($urandom_range(2, 1));
      end
    end
    finish_test(5, "mixed with gaps", 1100, err_before);

    if (result_count != ops_sent) begin
      $display("Got %0d results for %0d operations sent", result_count, ops_sent);
    end
    $display("Totals: %0d operations, %0d results, %0d errors",
             ops_sent, result_count, error_count);
    if (error_count == 0 && result_count == ops_sent) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
common/div_types_pkg.sv
common/div_cell_pkg.sv
divider/div_cell.sv
divider/div_array.sv
source/div_operand_stage.sv
source/div_result_stage.sv
source/approx_divider_top.sv
bench/div_checker.sv
bench/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the divider testbench with Verilator.
rm -f sim.log
verilator --binary --timing -f compile.f --top-module tb_top -o tb_sim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q '>>> PASS' sim.log && echo "run passed" || { echo "run failed"; exit 1; }
